// ==== include/calc_defs.svh ====
`ifndef CALC_DEFS_SVH
`define CALC_DEFS_SVH

// datapath and register file sizes
`define CALC_DATA_W      8
`define CALC_ADDR_W      5
`define CALC_RF_DEPTH    32

// keypad codes
`define CALC_KEY_W       4
`define CALC_DIGIT_MAX   9
`define CALC_OP_FIRST    10
`define CALC_OP_LAST     14
`define CALC_KEY_ENTER   15
`define CALC_KEY_NEXT    0

// each calculation takes digit 1, digit 2 and the result
`define CALC_SLOT_STRIDE 3
`define CALC_SLOT_LAST   27

// status LEDs, the top five bits show which key the controller expects
`define CALC_LED_W       16
`define CALC_PH_SELECT   5'b11111
`define CALC_PH_DIGIT1   5'b11101
`define CALC_PH_OPER     5'b11011
`define CALC_PH_DIGIT2   5'b10111
`define CALC_PH_ENTER    5'b10001

`endif

// ==== logic/calc_pkg.sv ====
`default_nettype none

`include "calc_defs.svh"

package calc_pkg;

    typedef logic [`CALC_DATA_W-1:0] data_t;
    typedef logic [`CALC_ADDR_W-1:0] reg_addr_t;
    typedef logic [`CALC_KEY_W-1:0]  key_code_t;
    typedef logic [`CALC_LED_W-1:0]  led_t;

    // operator encodings are the keypad codes themselves
    // none is only held until the first operator is latched
    typedef enum logic [`CALC_KEY_W-1:0] {
        ALU_NONE = 4'd0,
        ALU_ADD  = 4'd10,
        ALU_SUB  = 4'd11,
        ALU_AND  = 4'd12,
        ALU_OR   = 4'd13,
        ALU_XOR  = 4'd14
    } alu_op_t;

    typedef enum logic [4:0] {
        ST_SELECT, ST_DIGIT1, ST_D1_STORE, ST_D1_READ, ST_D1_SHOW,
        ST_OPER, ST_OP_LATCH,
        ST_DIGIT2, ST_D2_STORE, ST_D2_READ, ST_D2_SHOW,
        ST_ENTER, ST_EX_STORE, ST_EX_READ, ST_EX_SHOW,
        ST_REVIEW, ST_RV_READ, ST_RV_SHOW
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== logic/rf_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface rf_if import calc_pkg::*; ();

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    logic      we;
    data_t     wdata;
    data_t     rdata1;
    data_t     rdata2;

    modport ctrl (output rs1_addr, output rs2_addr, output rd_addr, output we);

    modport dp (input rdata1, input rdata2, output wdata);

    // reads are combinational, the write lands on the clock edge
    modport rf (
        input  rs1_addr, input rs2_addr, input rd_addr, input we, input wdata,
        output rdata1, output rdata2
    );

endinterface

`default_nettype wire

// ==== logic/ptr_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface ptr_if import calc_pkg::*; ();

    // one-cycle command pulses
    logic      latch_op;
    logic      adv_base;
    logic      adv_review;
    logic      set_err;
    logic      clr_err;
    key_code_t key;

    reg_addr_t base;
    reg_addr_t review;
    alu_op_t   op;
    logic      err;

    modport ctrl (
        output latch_op, output adv_base, output adv_review,
        output set_err, output clr_err, output key,
        input  base, input review, input op, input err
    );

    modport regs (
        input  latch_op, input adv_base, input adv_review,
        input  set_err, input clr_err, input key,
        output base, output review, output op, output err
    );

endinterface

`default_nettype wire

// ==== logic/slot_ptr_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "calc_defs.svh"

module slot_ptr_regs import calc_pkg::*; (
    input  wire logic clk_i,
    input  wire logic rst_i,
    ptr_if.regs       ptr
);

    // slot base walks 0, 3, ... up to the last slot and starts over
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            ptr.base <= '0;
        end else if (ptr.adv_base) begin
            if (ptr.base == reg_addr_t'(`CALC_SLOT_LAST)) begin
                ptr.base <= '0;
            end else begin
                ptr.base <= ptr.base + reg_addr_t'(`CALC_SLOT_STRIDE);
            end
        end
    end

    // the review pointer wraps from 31 to 0 at the address width
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            ptr.review <= '0;
        end else if (ptr.adv_review) begin
            ptr.review <= ptr.review + reg_addr_t'(1);
        end
    end

    // the key was range checked by the controller before latch_op
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            ptr.op <= ALU_NONE;
        end else if (ptr.latch_op) begin
            ptr.op <= alu_op_t'(ptr.key);
        end
    end

    // error LED holds until a key is accepted
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            ptr.err <= 1'b0;
        end else if (ptr.set_err) begin
            ptr.err <= 1'b1;
        end else if (ptr.clr_err) begin
            ptr.err <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "calc_defs.svh"

module reg_file import calc_pkg::*; (
    input  wire logic clk_i,
    input  wire logic rst_i,
    rf_if.rf          rf
);

    data_t mem [`CALC_RF_DEPTH];

    // entries never written must read back as zero in review mode
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            for (int i = 0; i < `CALC_RF_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (rf.we) begin
            mem[rf.rd_addr] <= rf.wdata;
        end
    end

    // read ports see the new value one cycle after the write
    assign rf.rdata1 = mem[rf.rs1_addr];
    assign rf.rdata2 = mem[rf.rs2_addr];

endmodule

`default_nettype wire

// ==== logic/calc_datapath.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "calc_defs.svh"

module calc_datapath import calc_pkg::*; (
    input  wire key_code_t key_code_i,
    input  wire alu_op_t   op_i,
    input  wire logic      sel_result_i,
    rf_if.dp               rf
);

    localparam int DigitPad = `CALC_DATA_W - `CALC_KEY_W;

    data_t alu_res;

    // add and sub wrap at the data width
    always_comb begin
        case (op_i)
            ALU_ADD: alu_res = rf.rdata1 + rf.rdata2;
            ALU_SUB: alu_res = rf.rdata1 - rf.rdata2;
            ALU_AND: alu_res = rf.rdata1 & rf.rdata2;
            ALU_OR:  alu_res = rf.rdata1 | rf.rdata2;
            ALU_XOR: alu_res = rf.rdata1 ^ rf.rdata2;
            default: alu_res = '0;
        endcase
    end

    // a digit is stored as its own value
    assign rf.wdata = sel_result_i ? alu_res : {{DigitPad{1'b0}}, key_code_i};

endmodule

`default_nettype wire

// ==== logic/calc_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "calc_defs.svh"

module calc_ctrl import calc_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      rst_i,
    input  wire key_code_t key_code_i,
    input  wire logic      key_valid_i,
    input  wire logic      mode_sw_i,
    rf_if.ctrl             rf,
    ptr_if.ctrl            ptr,
    output logic           sel_result_o,
    output logic           disp_we_o,
    output led_t           led_o
);

    localparam int LedPad = `CALC_LED_W - 5 - `CALC_KEY_W - 1;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    ctrl_state_t ok_state;
    key_code_t   key_q;
    reg_addr_t   addr_d1;
    reg_addr_t   addr_d2;
    reg_addr_t   addr_res;
    logic [4:0]  phase;
    logic        wait_st;
    logic        key_ok;
    logic        is_digit;
    logic        is_op;
    logic        is_enter;
    logic        is_next;

    assign is_digit = (key_code_i <= `CALC_DIGIT_MAX);
    assign is_op    = (key_code_i >= `CALC_OP_FIRST) && (key_code_i <= `CALC_OP_LAST);
    assign is_enter = (key_code_i == `CALC_KEY_ENTER);
    assign is_next  = (key_code_i == `CALC_KEY_NEXT);

    // the three entries of the current slot
    assign addr_d1  = ptr.base;
    assign addr_d2  = ptr.base + reg_addr_t'(1);
    assign addr_res = ptr.base + reg_addr_t'(2);

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            state_q <= ST_SELECT;
        end else begin
            state_q <= state_d;
        end
    end

    // the store states need the key after the strobe is gone
    always_ff @(posedge clk_i) begin
        if (wait_st && key_valid_i) begin
            key_q <= key_code_i;
        end
    end

    assign ptr.key = key_q;

    // ####################################################################
    // next state, register file addresses and command pulses
    // ####################################################################

    always_comb begin
        state_d        = state_q;
        ok_state       = state_q;
        wait_st        = 1'b0;
        key_ok         = 1'b0;
        phase          = `CALC_PH_SELECT;
        rf.rs1_addr    = addr_d1;
        rf.rs2_addr    = addr_d2;
        rf.rd_addr     = addr_res;
        rf.we          = 1'b0;
        sel_result_o   = 1'b0;
        disp_we_o      = 1'b0;
        ptr.latch_op   = 1'b0;
        ptr.adv_base   = 1'b0;
        ptr.adv_review = 1'b0;
        ptr.set_err    = 1'b0;
        ptr.clr_err    = 1'b0;

        case (state_q)
            ST_SELECT: begin
                if (mode_sw_i) begin
                    state_d = ST_REVIEW;
                end else begin
                    wait_st  = 1'b1;
                    key_ok   = is_digit;
                    ok_state = ST_D1_STORE;
                end
            end
            ST_D1_STORE: begin
                phase      = `CALC_PH_DIGIT1;
                rf.rd_addr = addr_d1;
                rf.we      = 1'b1;
                state_d    = ST_D1_READ;
            end
            ST_D1_READ, ST_D1_SHOW: begin
                phase     = `CALC_PH_DIGIT1;
                disp_we_o = (state_q == ST_D1_SHOW);
                state_d   = (state_q == ST_D1_SHOW) ? ST_OPER : ST_D1_SHOW;
            end
            ST_OPER: begin
                phase    = `CALC_PH_OPER;
                wait_st  = 1'b1;
                key_ok   = is_op;
                ok_state = ST_OP_LATCH;
            end
            ST_OP_LATCH: begin
                phase        = `CALC_PH_OPER;
                ptr.latch_op = 1'b1;
                state_d      = ST_DIGIT2;
            end
            ST_DIGIT2: begin
                phase    = `CALC_PH_DIGIT2;
                wait_st  = 1'b1;
                key_ok   = is_digit;
                ok_state = ST_D2_STORE;
            end
            ST_D2_STORE: begin
                phase      = `CALC_PH_DIGIT2;
                rf.rd_addr = addr_d2;
                rf.we      = 1'b1;
                state_d    = ST_D2_READ;
            end
            ST_D2_READ, ST_D2_SHOW: begin
                phase       = `CALC_PH_DIGIT2;
                rf.rs1_addr = addr_d2;
                disp_we_o   = (state_q == ST_D2_SHOW);
                state_d     = (state_q == ST_D2_SHOW) ? ST_ENTER : ST_D2_SHOW;
            end
            ST_ENTER: begin
                phase    = `CALC_PH_ENTER;
                wait_st  = 1'b1;
                key_ok   = is_enter;
                ok_state = ST_EX_STORE;
            end
            ST_EX_STORE: begin
                // both operands are read while the result is written
                phase        = `CALC_PH_ENTER;
                sel_result_o = 1'b1;
                rf.we        = 1'b1;
                state_d      = ST_EX_READ;
            end
            ST_EX_READ, ST_EX_SHOW: begin
                phase        = `CALC_PH_ENTER;
                rf.rs1_addr  = addr_res;
                disp_we_o    = (state_q == ST_EX_SHOW);
                ptr.adv_base = (state_q == ST_EX_SHOW);
                state_d      = (state_q == ST_EX_SHOW) ? ST_SELECT : ST_EX_SHOW;
            end
            ST_REVIEW: begin
                if (!mode_sw_i) begin
                    state_d = ST_SELECT;
                end else begin
                    wait_st  = 1'b1;
                    key_ok   = is_next;
                    ok_state = ST_RV_READ;
                end
            end
            ST_RV_READ, ST_RV_SHOW: begin
                rf.rs1_addr    = ptr.review;
                disp_we_o      = (state_q == ST_RV_SHOW);
                ptr.adv_review = (state_q == ST_RV_SHOW);
                state_d        = (state_q == ST_RV_SHOW) ? ST_REVIEW : ST_RV_SHOW;
            end
            default: state_d = ST_SELECT;
        endcase

        // a strobed key in a wait state is either taken or flagged
        if (wait_st && key_valid_i) begin
            if (key_ok) begin
                ptr.clr_err = 1'b1;
                state_d     = ok_state;
            end else begin
                ptr.set_err = 1'b1;
            end
        end
    end

    assign led_o = {phase, ptr.op, {LedPad{1'b0}}, ptr.err};

endmodule

`default_nettype wire

// ==== logic/calc_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module calc_top import calc_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      rst_i,
    input  wire key_code_t key_code_i,
    input  wire logic      key_valid_i,
    input  wire logic      mode_sw_i,
    output data_t          disp_data_o,
    output logic           disp_we_o,
    output led_t           led_o
);

    logic sel_result;

    rf_if  u_rf_if ();
    ptr_if u_ptr_if ();

    // ####################################################################
    // control
    // ####################################################################

    calc_ctrl u_calc_ctrl (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .key_code_i   (key_code_i),
        .key_valid_i  (key_valid_i),
        .mode_sw_i    (mode_sw_i),
        .rf           (u_rf_if.ctrl),
        .ptr          (u_ptr_if.ctrl),
        .sel_result_o (sel_result),
        .disp_we_o    (disp_we_o),
        .led_o        (led_o)
    );

    slot_ptr_regs u_slot_ptr_regs (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .ptr   (u_ptr_if.regs)
    );

    // ####################################################################
    // storage and ALU
    // ####################################################################

    reg_file u_reg_file (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .rf    (u_rf_if.rf)
    );

    // digit and operator come from the registers beside the controller
    calc_datapath u_calc_datapath (
        .key_code_i   (u_ptr_if.key),
        .op_i         (u_ptr_if.op),
        .sel_result_i (sel_result),
        .rf           (u_rf_if.dp)
    );

    assign disp_data_o = u_rf_if.rdata1;

endmodule

`default_nettype wire

// ==== dv/calc_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module calc_chk import calc_pkg::*; (
    input wire logic  clk_i,
    input wire logic  rst_i,
    input wire logic  disp_we_i,
    input wire data_t disp_data_i,
    input wire led_t  led_i
);

    int unsigned fail_cnt = 0;

    // the display strobe is a single-cycle pulse
    a_disp_we_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        disp_we_i |=> !disp_we_i)
        else begin
            fail_cnt++;
            $error("disp_we_o high for two cycles in a row");
        end

    a_disp_data_known: assert property (@(posedge clk_i) disable iff (rst_i)
        disp_we_i |-> !$isunknown(disp_data_i))
        else begin
            fail_cnt++;
            $error("disp_data_o unknown during a display write");
        end

    a_err_in_reset: assert property (@(posedge clk_i) rst_i |-> !led_i[0])
        else begin
            fail_cnt++;
            $error("error LED set during reset");
        end

endmodule

bind calc_top calc_chk u_calc_chk (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .disp_we_i   (disp_we_o),
    .disp_data_i (disp_data_o),
    .led_i       (led_o)
);

`default_nettype wire

// ==== dv/tb_calc.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "calc_defs.svh"

module tb_calc import calc_pkg::*; ();

    localparam int Timeout = 20;

    logic      clk_i;
    logic      rst_i;
    key_code_t key_code_i;
    logic      key_valid_i;
    logic      mode_sw_i;
    data_t     disp_data_o;
    logic      disp_we_o;
    led_t      led_o;

    // expected register file contents and pointers
    data_t  exp_mem [`CALC_RF_DEPTH];
    int     base;
    int     rv_ptr;
    int     errors;
    integer seed;

    calc_top u_calc_top (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .key_code_i  (key_code_i),
        .key_valid_i (key_valid_i),
        .mode_sw_i   (mode_sw_i),
        .disp_data_o (disp_data_o),
        .disp_we_o   (disp_we_o),
        .led_o       (led_o)
    );

    always #2 clk_i = ~clk_i;

    // keypad operators on 8-bit values, add and sub wrap mod 256
    function automatic data_t alu_model(input data_t a, input int op, input data_t b);
        case (op)
            10: return a + b;
            11: return a - b;
            12: return a & b;
            13: return a | b;
            14: return a ^ b;
            default: return 8'h00;
        endcase
    endfunction

    function automatic int rand_digit();
        return ($random(seed) & 32'h7fff_ffff) % (`CALC_DIGIT_MAX + 1);
    endfunction

    function automatic int rand_op();
        return `CALC_OP_FIRST + ($random(seed) & 32'h7fff_ffff) % 5;
    endfunction

    task automatic check_val(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic press_key(input int k);
        @(posedge clk_i);
        key_code_i  <= key_code_t'(k);
        key_valid_i <= 1'b1;
        @(posedge clk_i);
        key_valid_i <= 1'b0;
    endtask

    task automatic wait_phase(input logic [4:0] ph);
        int n;
        n = 0;
        @(negedge clk_i);
        while (led_o[15:11] !== ph && n < Timeout) begin
            @(negedge clk_i);
            n++;
        end
        if (led_o[15:11] !== ph) begin
            $display("timed out waiting for LED phase %b", ph);
            errors++;
        end
    endtask

    task automatic wait_disp(input data_t exp, input string what);
        int n;
        n = 0;
        @(negedge clk_i);
        while (!disp_we_o && n < Timeout) begin
            @(negedge clk_i);
            n++;
        end
        if (!disp_we_o) begin
            $display("no display write seen for %s", what);
            errors++;
        end else if (disp_data_o !== exp) begin
            $display("ERROR disp_data_o (%s): got %h, expected %h", what, disp_data_o, exp);
            errors++;
        end
    endtask

    task automatic reject_key(input logic [4:0] ph, input int k);
        int n;
        n = 0;
        wait_phase(ph);
        press_key(k);
        @(negedge clk_i);
        while (!led_o[0] && n < Timeout) begin
            @(negedge clk_i);
            n++;
        end
        if (!led_o[0]) begin
            $display("error LED not set after rejected key %0d", k);
            errors++;
        end
        check_val("led_o[15:11]", led_o[15:11], ph);
    endtask

    task automatic key_digit(input logic [4:0] ph, input int d, input int addr);
        wait_phase(ph);
        press_key(d);
        exp_mem[addr] = data_t'(d);
        wait_disp(exp_mem[addr], "digit");
        check_val("led_o[0]", led_o[0], 0);
    endtask

    // one calculation, with a rejected key ahead of three steps when bad is set
    task automatic run_calc(input int d1, input int op, input int d2, input bit bad);
        int res_addr;
        res_addr = base + 2;
        if (bad) begin
            reject_key(`CALC_PH_SELECT, op);
        end
        key_digit(`CALC_PH_SELECT, d1, base);
        if (bad) begin
            reject_key(`CALC_PH_OPER, d2);
        end
        wait_phase(`CALC_PH_OPER);
        press_key(op);
        wait_phase(`CALC_PH_DIGIT2);
        check_val("led_o[10:7]", led_o[10:7], op);
        check_val("led_o[0]", led_o[0], 0);
        key_digit(`CALC_PH_DIGIT2, d2, base + 1);
        if (bad) begin
            reject_key(`CALC_PH_ENTER, op);
        end
        wait_phase(`CALC_PH_ENTER);
        press_key(`CALC_KEY_ENTER);
        exp_mem[res_addr] = alu_model(exp_mem[base], op, exp_mem[base + 1]);
        wait_disp(exp_mem[res_addr], "result");
        base = (base == `CALC_SLOT_LAST) ? 0 : base + `CALC_SLOT_STRIDE;
        wait_phase(`CALC_PH_SELECT);
        check_val("led_o[0]", led_o[0], 0);
    endtask

    // steps the review pointer once around the whole register file
    task automatic review_all();
        @(posedge clk_i);
        mode_sw_i <= 1'b1;
        repeat (2) @(posedge clk_i);
        for (int i = 0; i < `CALC_RF_DEPTH; i++) begin
            press_key(`CALC_KEY_NEXT);
            wait_disp(exp_mem[rv_ptr], $sformatf("review entry %0d", rv_ptr));
            rv_ptr = (rv_ptr + 1) % `CALC_RF_DEPTH;
        end
        @(posedge clk_i);
        mode_sw_i <= 1'b0;
        repeat (2) @(posedge clk_i);
    endtask

    // ######################################################################
    // directed tests
    // ######################################################################

    task automatic test_reset();
        check_val("disp_we_o", disp_we_o, 0);
        check_val("led_o", led_o, {`CALC_PH_SELECT, 4'd0, 6'd0, 1'b0});
    endtask

    task automatic test_full_calc();
        for (int op = `CALC_OP_FIRST; op <= `CALC_OP_LAST; op++) begin
            run_calc(rand_digit(), op, rand_digit(), 1'b0);
        end
    endtask

    task automatic test_rejected_keys();
        run_calc(rand_digit(), rand_op(), rand_digit(), 1'b1);
    endtask

    task automatic test_review();
        review_all();
    endtask

    // slots 18 to 27 complete ten calculations, the last one lands on slot 0
    task automatic test_slot_wrap();
        repeat (5) run_calc(rand_digit(), rand_op(), rand_digit(), 1'b0);
        review_all();
    endtask

    initial begin
        seed        = 45;
        errors      = 0;
        base        = 0;
        rv_ptr      = 0;
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        key_code_i  = '0;
        key_valid_i = 1'b0;
        mode_sw_i   = 1'b0;
        for (int i = 0; i < `CALC_RF_DEPTH; i++) begin
            exp_mem[i] = '0;
        end
        repeat (10) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        test_reset();
        test_full_calc();
        test_rejected_keys();
        test_review();
        test_slot_wrap();
        $display("tb_calc done: %0d check errors, %0d assertion failures",
                 errors, u_calc_top.u_calc_chk.fail_cnt);
        if (errors == 0 && u_calc_top.u_calc_chk.fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
logic/calc_pkg.sv
logic/rf_if.sv
logic/ptr_if.sv
logic/slot_ptr_regs.sv
logic/reg_file.sv
logic/calc_datapath.sv
logic/calc_ctrl.sv
logic/calc_top.sv
dv/calc_chk.sv
dv/tb_calc.sv

// ==== Bender.yml ====
package:
  name: keypad_calc

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/calc_pkg.sv
      - logic/rf_if.sv
      - logic/ptr_if.sv
      - logic/slot_ptr_regs.sv
      - logic/reg_file.sv
      - logic/calc_datapath.sv
      - logic/calc_ctrl.sv
      - logic/calc_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/calc_chk.sv
      - dv/tb_calc.sv
